/* hdl/pt_walk_pkg.sv */
// Shared types for a four-level walk of 4 KB pages with 64-bit entries and 48-bit VA and PA
package pt_walk_pkg;

    // ==================================================
    // Table geometry
    // ==================================================

    // One 9-bit index per level, 512 entries per 4 KB page
    localparam int PT_IDX_BITS      = 9;
    localparam int PT_LEVELS        = 4;
    localparam int PAGE_OFFSET_BITS = 12;

    localparam int VA_BITS = 48;
    localparam int PA_BITS = 48;

    // Width of one table entry
    localparam int PTE_BITS = 64;

    // VA page number as a vector of indices
    // Element [PT_LEVELS-1] sits in the high bits and is the level 0 index
    typedef logic [PT_LEVELS-1:0][PT_IDX_BITS-1:0] va_page_t;

    // Physical page number
    typedef logic [PA_BITS-PAGE_OFFSET_BITS-1:0] pa_page_t;

    // Level currently being read, 0 is the root
    typedef logic [$clog2(PT_LEVELS)-1:0] walk_depth_t;

    // ==================================================
    // Entry layout
    // ==================================================

    // Terminal flag, set on the entry holding the translation
    localparam int PTE_TERMINAL_BIT = 0;
    // Error flag, an all-ones entry (unwritten) also has it set
    localparam int PTE_ERROR_BIT    = 3;
    // Low bit of the next page number inside the entry
    localparam int PTE_PAGE_LSB     = 12;

    typedef struct packed
    {
        logic error;
        logic terminal;
    } pte_status_t;

    // Decoded entry
    typedef struct packed
    {
        pte_status_t status;
        pa_page_t    next_page;
    } pte_t;

    // ==================================================
    // Control and port types
    // ==================================================

    // Walk FSM states
    typedef enum logic [2:0]
    {
        IDLE,
        READ_REQ,
        WAIT_RSP,
        EVAL,
        DONE,
        ERROR
    } walk_state_e;

    // Translation request, page granular
    typedef struct packed
    {
        va_page_t va_page;
    } walk_req_t;

    // Completed translation
    // big_page marks a 2 MB mapping found at level 2
    typedef struct packed
    {
        va_page_t va_page;
        pa_page_t pa_page;
        logic     big_page;
    } fill_t;

endpackage

/* hdl/pt_walk_ctrl.sv */
// Walk FSM that handles one request at a time and expects one read in flight at most
module pt_walk_ctrl
(
    input  logic              clk,
    input  logic              reset,

    // Configuration
    input  logic              enable,

    // Request handshake
    input  logic              req_valid,
    output logic              req_ready,

    // Line read handshake
    output logic              rd_valid,
    input  logic              rd_ready,

    // Decoded entry from the response path
    input  logic              pte_valid,
    input  pt_walk_pkg::pte_t pte,
    input  logic              last_level,

    // Result
    output logic              fill_valid,
    input  logic              fill_ready,
    output logic              not_present,

    // Cursor controls
    output logic              cursor_load,
    output logic              cursor_advance,
    output logic              cursor_take_next
);

    pt_walk_pkg::walk_state_e state;

    // Registered idle flag keeps req_ready off the state decode
    logic idle_q;

    logic req_accept;
    logic walk_error;
    logic walk_hit;

    // ==================================================
    // Handshake and decision terms
    // ==================================================

    assign req_ready  = enable && idle_q;
    assign req_accept = req_valid && req_ready;

    // Bad entry, or still pointing down after the last level
    assign walk_error = pte.status.error || (!pte.status.terminal && last_level);
    assign walk_hit   = pte.status.terminal && !pte.status.error;

    // New walk latches VA and root in the cursor
    assign cursor_load = req_accept;

    // Keep the next page on both hit and continue
    // On a hit it becomes the translated page
    assign cursor_take_next = (state == pt_walk_pkg::EVAL) && !walk_error;

    // Descend one level only when the walk continues
    assign cursor_advance = (state == pt_walk_pkg::EVAL) && !walk_error && !walk_hit;

    // ==================================================
    // State machine
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state       <= pt_walk_pkg::IDLE;
            idle_q      <= 1'b1;
            rd_valid    <= 1'b0;
            fill_valid  <= 1'b0;
            not_present <= 1'b0;
        end
        else
        begin
            case (state)
                pt_walk_pkg::IDLE:
                begin
                    if (req_accept)
                    begin
                        // First read goes out on the next cycle
                        state    <= pt_walk_pkg::READ_REQ;
                        idle_q   <= 1'b0;
                        rd_valid <= 1'b1;
                    end
                end

                pt_walk_pkg::READ_REQ:
                begin
                    // Hold address and valid until the memory takes it
                    if (rd_ready)
                    begin
                        state    <= pt_walk_pkg::WAIT_RSP;
                        rd_valid <= 1'b0;
                    end
                end

                pt_walk_pkg::WAIT_RSP:
                begin
                    // Variable memory delay plus two decode stages
                    if (pte_valid)
                    begin
                        state <= pt_walk_pkg::EVAL;
                    end
                end

                pt_walk_pkg::EVAL:
                begin
                    if (walk_error)
                    begin
                        state       <= pt_walk_pkg::ERROR;
                        not_present <= 1'b1;
                    end
                    else if (walk_hit)
                    begin
                        state      <= pt_walk_pkg::DONE;
                        fill_valid <= 1'b1;
                    end
                    else
                    begin
                        // Next level, cursor already stepping this cycle
                        state    <= pt_walk_pkg::READ_REQ;
                        rd_valid <= 1'b1;
                    end
                end

                pt_walk_pkg::DONE:
                begin
                    // Fill held stable under back-pressure
                    if (fill_ready)
                    begin
                        state      <= pt_walk_pkg::IDLE;
                        idle_q     <= 1'b1;
                        fill_valid <= 1'b0;
                    end
                end

                pt_walk_pkg::ERROR:
                begin
                    // Single-cycle not_present, then ready for the next walk
                    state       <= pt_walk_pkg::IDLE;
                    idle_q      <= 1'b1;
                    not_present <= 1'b0;
                end

                default:
                begin
                    state  <= pt_walk_pkg::IDLE;
                    idle_q <= 1'b1;
                end
            endcase
        end
    end

    // ==================================================
    // Checks
    // ==================================================

    // Read valid belongs to the request state only
    a_rd_valid_in_read_req: assert property (@(posedge clk) disable iff (reset)
        rd_valid |-> (state == pt_walk_pkg::READ_REQ));

    // Error is reported as a pulse
    a_not_present_pulse: assert property (@(posedge clk) disable iff (reset)
        not_present |=> !not_present);

endmodule

/* hdl/pt_walk_cursor.sv */
// Walk position for one VA at a time, LINE_WORDS must be a power of two from 4 to 16
module pt_walk_cursor
#(
    parameter int LINE_WORDS = 8
)
(
    input  logic                   clk,
    input  logic                   reset,

    input  pt_walk_pkg::pa_page_t  root_page,
    input  pt_walk_pkg::walk_req_t req,

    input  logic                   cursor_load,
    input  logic                   cursor_advance,
    input  logic                   cursor_take_next,
    input  pt_walk_pkg::pte_t      pte,

    output logic [$bits(pt_walk_pkg::pa_page_t)+pt_walk_pkg::PT_IDX_BITS
                  -$clog2(LINE_WORDS)-1:0] rd_addr,
    output logic [$clog2(LINE_WORDS)-1:0] word_idx,
    output logic                   last_level,
    output pt_walk_pkg::fill_t     fill
);

    // Index split into line within page and word within line
    localparam int WORD_IDX_BITS = $clog2(LINE_WORDS);
    localparam int LINE_IDX_BITS = pt_walk_pkg::PT_IDX_BITS - WORD_IDX_BITS;

    pt_walk_pkg::va_page_t    va_page_q;
    pt_walk_pkg::pa_page_t    cur_page;
    pt_walk_pkg::walk_depth_t depth;

    // Vector element for the current level, level 0 sits in the top element
    pt_walk_pkg::walk_depth_t            level_sel;
    logic [pt_walk_pkg::PT_IDX_BITS-1:0] level_idx;
    logic [LINE_IDX_BITS-1:0]            line_idx;

    // Depth is control state, VA and page are payload
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            depth <= '0;
        end
        else if (cursor_load)
        begin
            depth <= '0;
        end
        else if (cursor_advance)
        begin
            depth <= depth + pt_walk_pkg::walk_depth_t'(1);
        end

        if (cursor_load)
        begin
            va_page_q <= req.va_page;
            cur_page  <= root_page;
        end
        else if (cursor_take_next)
        begin
            // Table page while walking, translated page once terminal
            cur_page <= pte.next_page;
        end
    end

    assign level_sel = pt_walk_pkg::walk_depth_t'(pt_walk_pkg::PT_LEVELS - 1) - depth;
    assign level_idx = va_page_q[level_sel];
    assign {line_idx, word_idx} = level_idx;

    // Line address of the entry in the current table page
    assign rd_addr = {cur_page, line_idx};

    assign last_level = (depth == pt_walk_pkg::walk_depth_t'(pt_walk_pkg::PT_LEVELS - 1));

    // Terminal at level 2 maps 2 MB, at level 3 maps 4 KB
    assign fill.va_page  = va_page_q;
    assign fill.pa_page  = cur_page;
    assign fill.big_page = (depth == pt_walk_pkg::walk_depth_t'(pt_walk_pkg::PT_LEVELS - 2));

    // FSM must not step below the last level
    a_depth_limit: assert property (@(posedge clk) disable iff (reset)
        cursor_advance |-> !last_level);

endmodule

/* hdl/pt_rsp_decode.sv */
// Two-stage response path with no back-pressure, word_idx must hold while a beat is in flight
module pt_rsp_decode
#(
    parameter int LINE_WORDS = 8
)
(
    input  logic                                   clk,
    input  logic                                   reset,

    // Line response from memory
    input  logic                                   rsp_valid,
    input  logic [LINE_WORDS*pt_walk_pkg::PTE_BITS-1:0] rsp_data,

    // Entry position within the line, from the cursor
    input  logic [$clog2(LINE_WORDS)-1:0]          word_idx,

    // Decoded entry
    output logic                                   pte_valid,
    output pt_walk_pkg::pte_t                      pte
);

    // ==================================================
    // Stage 1, register the raw line
    // ==================================================

    // Line viewed as an array of entries
    logic [LINE_WORDS-1:0][pt_walk_pkg::PTE_BITS-1:0] line_q;
    logic                                             line_valid_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            line_valid_q <= 1'b0;
        end
        else
        begin
            line_valid_q <= rsp_valid;
        end

        // Payload only, qualified by line_valid_q
        line_q <= rsp_data;
    end

    // ==================================================
    // Stage 2, select and decode the entry
    // ==================================================

    logic [pt_walk_pkg::PTE_BITS-1:0] pte_word;
    pt_walk_pkg::pte_t                pte_next;

    assign pte_word = line_q[word_idx];

    always_comb
    begin
        pte_next.status.error    = pte_word[pt_walk_pkg::PTE_ERROR_BIT];
        pte_next.status.terminal = pte_word[pt_walk_pkg::PTE_TERMINAL_BIT];
        // Page number sits just above the 4 KB offset
        pte_next.next_page =
            pte_word[pt_walk_pkg::PTE_PAGE_LSB +: $bits(pt_walk_pkg::pa_page_t)];
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pte_valid <= 1'b0;
        end
        else
        begin
            pte_valid <= line_valid_q;
        end

        // Entry held until the next beat so the FSM can evaluate it later
        if (line_valid_q)
        begin
            pte <= pte_next;
        end
    end

    // Word position must not move between response and entry select
    a_word_idx_hold: assert property (@(posedge clk) disable iff (reset)
        line_valid_q |-> $stable(word_idx));

endmodule

/* hdl/pt_walker.sv */
// Page walker top, one walk in flight, memory must answer reads in order with no back-pressure
module pt_walker
#(
    parameter int LINE_WORDS = 8
)
(
    input  logic                   clk,
    input  logic                   reset,

    // Configuration, held steady between walks
    input  logic                   enable,
    input  pt_walk_pkg::pa_page_t  root_page,

    // Translation request
    input  logic                   req_valid,
    output logic                   req_ready,
    input  pt_walk_pkg::walk_req_t req,

    // Line read request
    output logic                   rd_valid,
    input  logic                   rd_ready,
    output logic [$bits(pt_walk_pkg::pa_page_t)+pt_walk_pkg::PT_IDX_BITS
                  -$clog2(LINE_WORDS)-1:0] rd_addr,

    // Line read response
    input  logic                   rsp_valid,
    input  logic [LINE_WORDS*pt_walk_pkg::PTE_BITS-1:0] rsp_data,

    // Result
    output logic                   fill_valid,
    input  logic                   fill_ready,
    output pt_walk_pkg::fill_t     fill,
    output logic                   not_present
);

    // FSM to cursor
    logic cursor_load;
    logic cursor_advance;
    logic cursor_take_next;

    // Response path to FSM and cursor
    logic              pte_valid;
    pt_walk_pkg::pte_t pte;

    // Cursor to FSM and response path
    logic                          last_level;
    logic [$clog2(LINE_WORDS)-1:0] word_idx;

    pt_walk_ctrl u_ctrl
    (
        .clk              (clk),
        .reset            (reset),
        .enable           (enable),
        .req_valid        (req_valid),
        .req_ready        (req_ready),
        .rd_valid         (rd_valid),
        .rd_ready         (rd_ready),
        .pte_valid        (pte_valid),
        .pte              (pte),
        .last_level       (last_level),
        .fill_valid       (fill_valid),
        .fill_ready       (fill_ready),
        .not_present      (not_present),
        .cursor_load      (cursor_load),
        .cursor_advance   (cursor_advance),
        .cursor_take_next (cursor_take_next)
    );

    pt_walk_cursor #(.LINE_WORDS(LINE_WORDS)) u_cursor
    (
        .clk              (clk),
        .reset            (reset),
        .root_page        (root_page),
        .req              (req),
        .cursor_load      (cursor_load),
        .cursor_advance   (cursor_advance),
        .cursor_take_next (cursor_take_next),
        .pte              (pte),
        .rd_addr          (rd_addr),
        .word_idx         (word_idx),
        .last_level       (last_level),
        .fill             (fill)
    );

    pt_rsp_decode #(.LINE_WORDS(LINE_WORDS)) u_decode
    (
        .clk       (clk),
        .reset     (reset),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .word_idx  (word_idx),
        .pte_valid (pte_valid),
        .pte       (pte)
    );

endmodule

/* sim/pt_mem_model.sv */
// Table memory for the walker testbench, one read in flight, table pages only come from map requests
module pt_mem_model
#(
    parameter int                    LINE_WORDS = 8,
    parameter pt_walk_pkg::pa_page_t LEAF_XOR   = '0
)
(
    input  logic                  clk,
    input  logic                  reset,

    // Table build, one VA per cycle
    input  logic                  map_valid,
    input  pt_walk_pkg::va_page_t map_va,
    input  logic                  map_big,
    input  logic                  map_error,
    input  logic                  map_deep,
    input  pt_walk_pkg::pa_page_t root_page,

    // Per-cycle random controls from the testbench
    input  logic [2:0]            rsp_delay,
    input  logic                  accept_en,

    // Line read port of the walker
    input  logic                  rd_valid,
    output logic                  rd_ready,
    input  logic [$bits(pt_walk_pkg::pa_page_t)+pt_walk_pkg::PT_IDX_BITS
                  -$clog2(LINE_WORDS)-1:0] rd_addr,
    output logic                  rsp_valid,
    output logic [LINE_WORDS*pt_walk_pkg::PTE_BITS-1:0] rsp_data,

    // High for one cycle after a read outside every built page
    output logic                  bad_read
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PAGE_BITS = $bits(pt_walk_pkg::pa_page_t);
    localparam int WORD_BITS = $clog2(LINE_WORDS);
    localparam int ADDR_BITS = PAGE_BITS + pt_walk_pkg::PT_IDX_BITS - WORD_BITS;

    // Scrambles table page numbers
    localparam pt_walk_pkg::pa_page_t TABLE_XOR = 36'h9_e377_9b97;

    typedef logic [LINE_WORDS-1:0][pt_walk_pkg::PTE_BITS-1:0] line_t;

    // Sparse table, lines never written read back as all ones
    line_t lines [logic [ADDR_BITS-1:0]];
    logic  built [pt_walk_pkg::pa_page_t];

    logic                 busy;
    logic [2:0]           delay_left;
    logic [ADDR_BITS-1:0] addr_q;

    // ==================================================
    // Table construction
    // ==================================================

    // Child table page from parent page and index
    function automatic pt_walk_pkg::pa_page_t child_page(input pt_walk_pkg::pa_page_t parent,
                                                         input logic [8:0] idx);
        return {parent[PAGE_BITS-pt_walk_pkg::PT_IDX_BITS-1:0], idx} ^ TABLE_XOR;
    endfunction

    function automatic logic [63:0] pointer_entry(input pt_walk_pkg::pa_page_t page);
        logic [63:0] entry;
        entry = '0;
        entry[pt_walk_pkg::PTE_PAGE_LSB +: PAGE_BITS] = page;
        return entry;
    endfunction

    // Fills the rest of a new line with all ones
    task automatic write_entry(input pt_walk_pkg::pa_page_t page, input logic [8:0] idx,
                               input logic [63:0] entry);
        logic [ADDR_BITS-1:0] addr;
        line_t                line;
        addr = {page, idx[8:WORD_BITS]};
        if (lines.exists(addr))
        begin
            line = lines[addr];
        end
        else
        begin
            line = '1;
        end
        line[idx[WORD_BITS-1:0]] = entry;
        lines[addr] = line;
    endtask

    always @(posedge clk)
    begin : table_build
        logic [PAGE_BITS-1:0]  va_flat;
        pt_walk_pkg::pa_page_t page;
        pt_walk_pkg::pa_page_t child;
        logic [63:0]           entry;
        logic [8:0]            idx;
        logic                  stop;
        int                    lvl;
        if (map_valid)
        begin
            va_flat     = map_va;
            page        = root_page;
            stop        = 1'b0;
            built[page] = 1'b1;
            for (lvl = 0; lvl < pt_walk_pkg::PT_LEVELS; lvl++)
            begin
                if (!stop)
                begin
                    // Level 0 index in the top bits
                    idx   = 9'(va_flat >> (pt_walk_pkg::PT_IDX_BITS * (3 - lvl)));
                    child = child_page(page, idx);
                    if (lvl == 2 && map_big)
                    begin
                        // 2 MB leaf, page from the upper three indices
                        entry = pointer_entry({va_flat[PAGE_BITS-1:9], 9'h000} ^ LEAF_XOR);
                        entry[pt_walk_pkg::PTE_TERMINAL_BIT] = 1'b1;
                        stop  = 1'b1;
                    end
                    else if (lvl == 3 && !map_deep)
                    begin
                        entry = pointer_entry(va_flat ^ LEAF_XOR);
                        entry[pt_walk_pkg::PTE_TERMINAL_BIT] = 1'b1;
                    end
                    else
                    begin
                        // Pointer down, deep VAs keep one below the last level
                        entry = pointer_entry(child);
                        entry[pt_walk_pkg::PTE_ERROR_BIT] = map_error && (lvl == 1);
                        stop         = entry[pt_walk_pkg::PTE_ERROR_BIT];
                        built[child] = 1'b1;
                    end
                    write_entry(page, idx, entry);
                    page = child;
                end
            end
        end
    end

    // ==================================================
    // Read port
    // ==================================================

    assign rd_ready = accept_en && !busy;

    always @(posedge clk)
    begin
        if (reset)
        begin
            busy      <= 1'b0;
            rsp_valid <= 1'b0;
            bad_read  <= 1'b0;
        end
        else
        begin
            rsp_valid <= 1'b0;
            bad_read  <= rd_valid && rd_ready && !built.exists(rd_addr[ADDR_BITS-1 -: PAGE_BITS]);
            if (rd_valid && rd_ready)
            begin
                busy       <= 1'b1;
                delay_left <= rsp_delay;
                addr_q     <= rd_addr;
            end
            else if (busy)
            begin
                if (delay_left == 3'd0)
                begin
                    // One beat per read, no back-pressure
                    busy      <= 1'b0;
                    rsp_valid <= 1'b1;
                    rsp_data  <= lines.exists(addr_q) ? lines[addr_q] : '1;
                end
                else
                begin
                    delay_left <= delay_left - 3'd1;
                end
            end
        end
    end

endmodule

/* sim/tb_pt_walker.sv */
// Walker testbench with LINE_WORDS 8, walks run one after another and the first error stops the run
module tb_pt_walker;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int LINE_WORDS = 8;
    localparam int ADDR_BITS  = $bits(pt_walk_pkg::pa_page_t) + pt_walk_pkg::PT_IDX_BITS
                                - $clog2(LINE_WORDS);
    localparam int NUM_WALKS      = 12;
    localparam int TIMEOUT_CYCLES = NUM_WALKS * 4 * (7 + 10) + 100;

    localparam pt_walk_pkg::pa_page_t ROOT_PAGE = 36'h0_0004_2000;
    localparam pt_walk_pkg::pa_page_t LEAF_XOR  = 36'h0_5c3a_e1d7;
    localparam logic [31:0]           SEED      = 32'h2ace3358;

    // Expected outcome of each walk
    localparam int KIND_NORMAL  = 0;
    localparam int KIND_BIG     = 1;
    localparam int KIND_ERROR   = 2;
    localparam int KIND_DEEP    = 3;
    localparam int KIND_MISSING = 4;

    logic clk;
    logic reset;
    logic enable;
    logic req_valid;
    logic req_ready;
    logic rd_valid;
    logic rd_ready;
    logic rsp_valid;
    logic fill_valid;
    logic fill_ready;
    logic not_present;
    logic map_valid;
    logic map_big;
    logic map_error;
    logic map_deep;
    logic accept_en;
    logic bad_read;
    logic in_walk;
    logic [2:0]            rsp_delay;
    logic [ADDR_BITS-1:0]  rd_addr;
    logic [LINE_WORDS*pt_walk_pkg::PTE_BITS-1:0] rsp_data;
    logic [31:0]           lfsr;
    int                    cycle_count = 0;
    pt_walk_pkg::pa_page_t root_page;
    pt_walk_pkg::walk_req_t req;
    pt_walk_pkg::fill_t    fill;
    pt_walk_pkg::va_page_t map_va;
    pt_walk_pkg::va_page_t va_list [NUM_WALKS];

    pt_walker #(.LINE_WORDS(LINE_WORDS)) dut
    (
        .clk (clk), .reset (reset), .enable (enable), .root_page (root_page),
        .req_valid (req_valid), .req_ready (req_ready), .req (req),
        .rd_valid (rd_valid), .rd_ready (rd_ready), .rd_addr (rd_addr),
        .rsp_valid (rsp_valid), .rsp_data (rsp_data),
        .fill_valid (fill_valid), .fill_ready (fill_ready), .fill (fill),
        .not_present (not_present)
    );

    pt_mem_model #(.LINE_WORDS(LINE_WORDS), .LEAF_XOR(LEAF_XOR)) mem
    (
        .clk (clk), .reset (reset), .map_valid (map_valid), .map_va (map_va),
        .map_big (map_big), .map_error (map_error), .map_deep (map_deep),
        .root_page (root_page), .rsp_delay (rsp_delay), .accept_en (accept_en),
        .rd_valid (rd_valid), .rd_ready (rd_ready), .rd_addr (rd_addr),
        .rsp_valid (rsp_valid), .rsp_data (rsp_data), .bad_read (bad_read)
    );

    // ==================================================
    // Helpers
    // ==================================================

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        int          k;
        bits = '0;
        for (k = 0; k < n; k++)
        begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic int walk_kind(input int i);
        case (i)
            2, 10:   return KIND_BIG;
            4:       return KIND_ERROR;
            6:       return KIND_MISSING;
            8:       return KIND_DEEP;
            default: return KIND_NORMAL;
        endcase
    endfunction

    // Unique level 0 index per walk, missing VAs use a root line nobody maps
    function automatic pt_walk_pkg::va_page_t make_va(input int i);
        logic [8:0] top;
        top = (walk_kind(i) == KIND_MISSING) ? 9'(256 + i) : 9'(i);
        return {top, 27'(rand_bits(27))};
    endfunction

    function automatic logic [35:0] expected_page(input logic [35:0] va, input logic big);
        if (big)
        begin
            return {va[35:9], 9'h000} ^ LEAF_XOR;
        end
        return va ^ LEAF_XOR;
    endfunction

    task automatic check_value(input string name, input logic [35:0] expected,
                               input logic [35:0] actual);
        if (actual !== expected)
        begin
            stop_on_error($sformatf("MISMATCH %s expected %h got %h", name, expected, actual));
        end
    endtask

    // Next falling edge, new random back-pressure and delay
    task automatic next_cycle();
        @(negedge clk);
        fill_ready = 1'(rand_bits(1));
        rsp_delay  = 3'(rand_bits(3));
        accept_en  = 1'(rand_bits(1));
    endtask

    task automatic run_walk(input int i);
        int   kind;
        logic accepted;
        logic done;
        kind          = walk_kind(i);
        req.va_page   = va_list[i];
        req_valid     = 1'b1;
        accepted      = 1'b0;
        while (!accepted)
        begin
            accepted = req_ready;
            next_cycle();
        end
        req_valid = 1'b0;
        done      = 1'b0;
        while (!done)
        begin
            if (not_present)
            begin
                if (kind == KIND_NORMAL || kind == KIND_BIG)
                begin
                    stop_on_error($sformatf("walk %0d reported not_present for a mapped VA", i));
                end
                done = 1'b1;
            end
            else if (fill_valid && fill_ready)
            begin
                if (kind != KIND_NORMAL && kind != KIND_BIG)
                begin
                    stop_on_error($sformatf("walk %0d returned a fill for an unmapped VA", i));
                end
                check_value("fill.va_page", va_list[i], fill.va_page);
                check_value("fill.pa_page", expected_page(va_list[i], kind == KIND_BIG),
                            fill.pa_page);
                check_value("fill.big_page", 36'(kind == KIND_BIG), 36'(fill.big_page));
                done = 1'b1;
            end
            next_cycle();
        end
    endtask

    // ==================================================
    // Clock, monitors and checks
    // ==================================================

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Walk in flight from acceptance to fill transfer or not_present
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            in_walk <= 1'b0;
        end
        else if (req_valid && req_ready)
        begin
            in_walk <= 1'b1;
        end
        else if ((fill_valid && fill_ready) || not_present)
        begin
            in_walk <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES)
        begin
            stop_on_error($sformatf("timeout, walks not finished after %0d cycles", cycle_count));
        end
    end

    a_fill_stable: assert property (@(posedge clk) disable iff (reset)
        fill_valid && !fill_ready |=> fill_valid && $stable(fill))
        else stop_on_error("fill dropped or changed while fill_ready was low");

    a_rd_addr_stable: assert property (@(posedge clk) disable iff (reset)
        rd_valid && !rd_ready |=> rd_valid && $stable(rd_addr))
        else stop_on_error("read request dropped or changed while rd_ready was low");

    a_busy_not_ready: assert property (@(posedge clk) disable iff (reset)
        in_walk |-> !req_ready)
        else stop_on_error("req_ready high while a walk was in flight");

    a_disabled_quiet: assert property (@(posedge clk) disable iff (reset)
        !enable |-> !req_ready && !rd_valid)
        else stop_on_error("walker active while enable was low");

    a_single_pulse: assert property (@(posedge clk) disable iff (reset)
        not_present |=> !not_present)
        else stop_on_error("not_present lasted more than one cycle");

    a_read_in_table: assert property (@(posedge clk) disable iff (reset)
        !bad_read)
        else stop_on_error("read outside page table");

    // ==================================================
    // Stimulus
    // ==================================================

    initial
    begin
        int i;
        lfsr        = SEED;
        reset       = 1'b1;
        enable      = 1'b0;
        root_page   = ROOT_PAGE;
        req_valid   = 1'b0;
        req         = '0;
        fill_ready  = 1'b0;
        rsp_delay   = 3'd0;
        accept_en   = 1'b0;
        map_valid   = 1'b0;
        map_va      = '0;
        map_big     = 1'b0;
        map_error   = 1'b0;
        map_deep    = 1'b0;
        for (i = 0; i < NUM_WALKS; i++)
        begin
            va_list[i] = make_va(i);
        end

        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Build the table while disabled, a pending request must not start
        req_valid   = 1'b1;
        req.va_page = va_list[0];
        for (i = 0; i < NUM_WALKS; i++)
        begin
            map_valid = (walk_kind(i) != KIND_MISSING);
            map_va    = va_list[i];
            map_big   = (walk_kind(i) == KIND_BIG);
            map_error = (walk_kind(i) == KIND_ERROR);
            map_deep  = (walk_kind(i) == KIND_DEEP);
            next_cycle();
        end
        map_valid = 1'b0;
        repeat (4) next_cycle();

        enable    = 1'b1;
        req_valid = 1'b0;
        for (i = 0; i < NUM_WALKS; i++)
        begin
            run_walk(i);
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

/* vlog.f */
hdl/pt_walk_pkg.sv
hdl/pt_walk_ctrl.sv
hdl/pt_walk_cursor.sv
hdl/pt_rsp_decode.sv
hdl/pt_walker.sv
sim/pt_mem_model.sv
sim/tb_pt_walker.sv

/* Makefile */
# Verilator build and run of the page table walker testbench

VERILATOR ?= verilator
TOP       ?= tb_pt_walker
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= NO ERRORS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
